// File: source/ooo_pkg.sv
`default_nettype none

package ooo_pkg;

    // ------------------------------------------------------------------
    // Widths that carry a meaning
    // ------------------------------------------------------------------
    typedef logic [31:0] word_t;
    typedef logic [2:0]  rob_tag_t;   // Tag 0 means the value is present.
    typedef logic [4:0]  reg_idx_t;
    typedef logic [4:0]  op_t;

    localparam op_t OP_ADD   = 5'b00000;
    localparam op_t OP_AND   = 5'b00001;
    localparam op_t OP_OR    = 5'b00010;
    localparam op_t OP_SLL   = 5'b00011;
    localparam op_t OP_SRL   = 5'b00100;
    localparam op_t OP_SLT   = 5'b00101;
    localparam op_t OP_SLTU  = 5'b00110;
    localparam op_t OP_SRA   = 5'b00111;
    localparam op_t OP_SUB   = 5'b01000;
    localparam op_t OP_XOR   = 5'b01001;
    localparam op_t OP_BEQ   = 5'b01010;
    localparam op_t OP_BGE   = 5'b01011;
    localparam op_t OP_BNE   = 5'b01100;
    localparam op_t OP_BGEU  = 5'b01101;
    localparam op_t OP_LUI   = 5'b01110;
    localparam op_t OP_AUIPC = 5'b01111;
    localparam op_t OP_JAL   = 5'b10000;
    localparam op_t OP_BLT   = 5'b11010;
    localparam op_t OP_BLTU  = 5'b11011;
    localparam op_t OP_NONE  = 5'b11111; // Empty dispatch slot.

    // ------------------------------------------------------------------
    // Bundles between the blocks
    // ------------------------------------------------------------------
    typedef struct packed {
        op_t      op;
        reg_idx_t rd;
        word_t    imm;
        logic     has_imm;
        word_t    pc;
        word_t    value1;
        rob_tag_t tag1;
        word_t    value2;
        rob_tag_t tag2;
    } dispatch_t;

    typedef struct packed {
        logic     valid;
        op_t      op;
        word_t    value1;
        rob_tag_t tag1;
        word_t    value2;
        rob_tag_t tag2;
        rob_tag_t dest;
    } issue_t;

    // For a branch the value is the taken flag.
    typedef struct packed {
        logic     valid;
        rob_tag_t tag;
        word_t    value;
    } cdb_t;

    typedef struct packed {
        logic     valid;
        rob_tag_t tag;
        reg_idx_t rd;
        word_t    value;
    } commit_t;

    typedef struct packed {
        logic  valid;
        word_t target;
    } redirect_t;

    typedef enum logic [1:0] {RS_IDLE, RS_WAIT, RS_DONE} station_state_t;

    function automatic logic is_branch_op(op_t op);
        return (op == OP_BEQ) || (op == OP_BNE) || (op == OP_BLT) ||
               (op == OP_BGE) || (op == OP_BLTU) || (op == OP_BGEU);
    endfunction

endpackage

`default_nettype wire

// File: source/reorder_buffer.sv
`timescale 1ns/100ps
`default_nettype none

module reorder_buffer
    import ooo_pkg::*;
(
    input  wire            clk,
    input  wire            rst,
    input  wire dispatch_t dispatch,
    output logic           dispatch_ready,
    input  wire            station_free,
    output issue_t         issue,
    input  wire cdb_t      cdb,
    output commit_t        commit,
    output redirect_t      redirect,
    output logic           flush
);

    // Entries 1 to 7; tag 0 is reserved for "value present".
    logic     entry_busy  [1:7];
    logic     entry_done  [1:7];
    op_t      entry_op    [1:7];
    reg_idx_t entry_rd    [1:7];
    word_t    entry_pc    [1:7];
    word_t    entry_imm   [1:7];
    word_t    entry_value [1:7];

    rob_tag_t   head;
    rob_tag_t   tail;
    logic [2:0] count;
    logic       in_service; // Low until the first edge out of reset.

    logic  needs_station;
    logic  accept;
    logic  retire;
    word_t alloc_value;

    function automatic rob_tag_t next_tag(rob_tag_t t);
        return (t == 3'd7) ? 3'd1 : t + 3'd1;
    endfunction

    // An operand is known if given directly, held by a finished entry, or on the bus now.
    function automatic logic operand_known(rob_tag_t t);
        if (t == 3'd0) begin
            return 1'b1;
        end
        if (entry_busy[t] && entry_done[t]) begin
            return 1'b1;
        end
        return cdb.valid && (cdb.tag == t);
    endfunction

    function automatic word_t operand_value(word_t v, rob_tag_t t);
        if (t == 3'd0) begin
            return v;
        end
        if (entry_busy[t] && entry_done[t]) begin
            return entry_value[t];
        end
        if (cdb.valid && (cdb.tag == t)) begin
            return cdb.value;
        end
        return '0;
    endfunction

    // ------------------------------------------------------------------
    // Dispatch side
    // ------------------------------------------------------------------
    always_comb begin
        needs_station = !((dispatch.op == OP_LUI) || (dispatch.op == OP_AUIPC) ||
                          (dispatch.op == OP_JAL));
        dispatch_ready = in_service && (count != 3'd7) && (!needs_station || station_free);
        accept = (dispatch.op != OP_NONE) && dispatch_ready;

        case (dispatch.op)
            OP_LUI:   alloc_value = dispatch.imm;
            OP_AUIPC: alloc_value = dispatch.pc + dispatch.imm;
            OP_JAL:   alloc_value = dispatch.pc + 32'd4;
            default:  alloc_value = '0;
        endcase
    end

    always_comb begin
        issue.valid  = accept && needs_station && !flush; // Wrong-path slot is dropped.
        issue.op     = dispatch.op;
        issue.dest   = tail;
        issue.value1 = operand_value(dispatch.value1, dispatch.tag1);
        issue.tag1   = operand_known(dispatch.tag1) ? 3'd0 : dispatch.tag1;

        // Branches compare two registers; the immediate is their offset.
        if (dispatch.has_imm && !is_branch_op(dispatch.op)) begin
            issue.value2 = dispatch.imm;
            issue.tag2   = 3'd0;
        end else begin
            issue.value2 = operand_value(dispatch.value2, dispatch.tag2);
            issue.tag2   = operand_known(dispatch.tag2) ? 3'd0 : dispatch.tag2;
        end
    end

    // ------------------------------------------------------------------
    // Commit side
    // ------------------------------------------------------------------
    always_comb begin
        retire = entry_busy[head] && entry_done[head];
        flush  = retire && ((entry_op[head] == OP_JAL) ||
                            (is_branch_op(entry_op[head]) && entry_value[head][0]));
    end

    always_ff @(posedge clk) begin
        if (!rst) begin
            in_service <= 1'b0;
            head       <= 3'd1;
            tail       <= 3'd1;
            count      <= 3'd0;
            commit     <= '0;
            redirect   <= '0;
            for (int i = 1; i <= 7; i++) begin
                entry_busy[i] <= 1'b0;
                entry_done[i] <= 1'b0;
            end
        end else begin
            in_service <= 1'b1;
            commit     <= '0;
            redirect   <= '0;

            if (cdb.valid) begin
                entry_done[cdb.tag]  <= 1'b1;
                entry_value[cdb.tag] <= cdb.value;
            end

            if (retire) begin
                entry_busy[head] <= 1'b0;
                commit.valid     <= 1'b1;
                commit.tag       <= head;
                commit.rd        <= entry_rd[head];
                commit.value     <= entry_value[head];
                head             <= next_tag(head);
            end

            if (flush) begin
                // Everything behind the committing entry is on the wrong path.
                redirect.valid  <= 1'b1;
                redirect.target <= entry_pc[head] + entry_imm[head];
                for (int i = 1; i <= 7; i++) begin
                    entry_busy[i] <= 1'b0;
                    entry_done[i] <= 1'b0;
                end
                tail  <= next_tag(head);
                count <= 3'd0;
            end else begin
                if (accept) begin
                    entry_busy[tail]  <= 1'b1;
                    entry_done[tail]  <= !needs_station;
                    entry_op[tail]    <= dispatch.op;
                    entry_rd[tail]    <= dispatch.rd;
                    entry_pc[tail]    <= dispatch.pc;
                    entry_imm[tail]   <= dispatch.imm;
                    entry_value[tail] <= alloc_value;
                    tail              <= next_tag(tail);
                end
                count <= count + {2'b00, accept} - {2'b00, retire};
            end
        end
    end

endmodule

`default_nettype wire

// File: source/issue_router.sv
`timescale 1ns/100ps
`default_nettype none

module issue_router
    import ooo_pkg::*;
#(
    parameter int NUM_STATIONS = 3
) (
    input  wire issue_t            issue,
    input  wire [NUM_STATIONS-1:0] busy,
    output issue_t                 station_issue [NUM_STATIONS],
    output logic                   station_free
);

    logic [NUM_STATIONS-1:0] pick;

    // Lowest idle station wins.
    always_comb begin
        pick = '0;
        for (int i = 0; i < NUM_STATIONS; i++) begin
            if (!busy[i] && (pick == '0)) begin
                pick[i] = 1'b1;
            end
        end
    end

    always_comb begin
        for (int i = 0; i < NUM_STATIONS; i++) begin
            station_issue[i]       = issue;
            station_issue[i].valid = issue.valid && pick[i];
        end
        station_free = |pick;
    end

endmodule

`default_nettype wire

// File: source/alu_station.sv
`timescale 1ns/100ps
`default_nettype none

module alu_station
    import ooo_pkg::*;
(
    input  wire         clk,
    input  wire         rst,
    input  wire         flush,
    input  wire issue_t issue,
    input  wire cdb_t   cdb,
    input  wire         grant,
    output logic        busy,
    output cdb_t        request
);

    station_state_t state;
    op_t            op;
    word_t          value1;
    word_t          value2;
    rob_tag_t       tag1;
    rob_tag_t       tag2;
    rob_tag_t       dest;
    word_t          result;

    function automatic word_t execute(op_t code, word_t a, word_t b);
        case (code)
            OP_ADD:  return a + b;
            OP_SUB:  return a - b;
            OP_AND:  return a & b;
            OP_OR:   return a | b;
            OP_XOR:  return a ^ b;
            OP_SLL:  return a << b[4:0];
            OP_SRL:  return a >> b[4:0];
            OP_SRA:  return word_t'($signed(a) >>> b[4:0]);
            OP_SLT:  return {31'd0, $signed(a) < $signed(b)};
            OP_SLTU: return {31'd0, a < b};
            // Branches give the taken flag.
            OP_BEQ:  return {31'd0, a == b};
            OP_BNE:  return {31'd0, a != b};
            OP_BLT:  return {31'd0, $signed(a) < $signed(b)};
            OP_BGE:  return {31'd0, $signed(a) >= $signed(b)};
            OP_BLTU: return {31'd0, a < b};
            OP_BGEU: return {31'd0, a >= b};
            default: return '0;
        endcase
    endfunction

    always_ff @(posedge clk) begin
        if (!rst || flush) begin
            state <= RS_IDLE;
        end else begin
            case (state)
                RS_IDLE: if (issue.valid) state <= RS_WAIT;
                RS_WAIT: if ((tag1 == 3'd0) && (tag2 == 3'd0)) state <= RS_DONE;
                RS_DONE: if (grant) state <= RS_IDLE; // Freed on the grant edge.
                default: state <= RS_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if ((state == RS_IDLE) && issue.valid) begin
            op     <= issue.op;
            value1 <= issue.value1;
            tag1   <= issue.tag1;
            value2 <= issue.value2;
            tag2   <= issue.tag2;
            dest   <= issue.dest;
        end else if (state == RS_WAIT) begin
            // Snoop the bus for whatever is still missing.
            if (cdb.valid && (tag1 != 3'd0) && (cdb.tag == tag1)) begin
                value1 <= cdb.value;
                tag1   <= 3'd0;
            end
            if (cdb.valid && (tag2 != 3'd0) && (cdb.tag == tag2)) begin
                value2 <= cdb.value;
                tag2   <= 3'd0;
            end
            if ((tag1 == 3'd0) && (tag2 == 3'd0)) begin
                result <= execute(op, value1, value2);
            end
        end
    end

    always_comb begin
        busy          = (state != RS_IDLE);
        request.valid = (state == RS_DONE);
        request.tag   = dest;
        request.value = result;
    end

endmodule

`default_nettype wire

// File: source/cdb_arbiter.sv
`timescale 1ns/100ps
`default_nettype none

module cdb_arbiter
    import ooo_pkg::*;
#(
    parameter int NUM_STATIONS = 3
) (
    input  wire                    clk,
    input  wire                    rst,
    input  wire cdb_t              request [NUM_STATIONS],
    output logic [NUM_STATIONS-1:0] grant,
    output cdb_t                   cdb
);

    localparam int IDX_W = (NUM_STATIONS > 1) ? $clog2(NUM_STATIONS) : 1;

    logic [IDX_W-1:0] last;   // Previous winner.
    logic [IDX_W-1:0] winner;
    logic             found;

    // Search starts just after the last winner and wraps around.
    always_comb begin
        int idx;
        grant  = '0;
        cdb    = '0;
        winner = last;
        found  = 1'b0;
        for (int k = 1; k <= NUM_STATIONS; k++) begin
            idx = (int'(last) + k) % NUM_STATIONS;
            if (!found && request[idx].valid) begin
                found  = 1'b1;
                winner = IDX_W'(idx);
            end
        end
        if (found) begin
            grant[winner] = 1'b1;
            cdb           = request[winner];
        end
    end

    always_ff @(posedge clk) begin
        if (!rst) begin
            last <= IDX_W'(NUM_STATIONS - 1); // Station 0 goes first.
        end else if (found) begin
            last <= winner;
        end
    end

endmodule

`default_nettype wire

// File: source/ooo_core.sv
`timescale 1ns/100ps
`default_nettype none

module ooo_core
    import ooo_pkg::*;
#(
    parameter int NUM_STATIONS = 3
) (
    input  wire            clk,
    input  wire            rst,
    input  wire dispatch_t dispatch,
    output logic           dispatch_ready,
    output commit_t        commit,
    output redirect_t      redirect
);

    issue_t                  issue;
    issue_t                  station_issue [NUM_STATIONS];
    cdb_t                    request [NUM_STATIONS];
    cdb_t                    cdb;
    logic [NUM_STATIONS-1:0] busy;
    logic [NUM_STATIONS-1:0] grant;
    logic                    station_free;
    logic                    flush;

    reorder_buffer rob (
        .clk(clk), .rst(rst),
        .dispatch(dispatch), .dispatch_ready(dispatch_ready),
        .station_free(station_free), .issue(issue), .cdb(cdb),
        .commit(commit), .redirect(redirect), .flush(flush)
    );

    issue_router #(.NUM_STATIONS(NUM_STATIONS)) router (
        .issue(issue), .busy(busy),
        .station_issue(station_issue), .station_free(station_free)
    );

    // ------------------------------------------------------------------
    // Reservation stations
    // ------------------------------------------------------------------
    for (genvar i = 0; i < NUM_STATIONS; i++) begin : g_station
        alu_station station (
            .clk(clk), .rst(rst), .flush(flush),
            .issue(station_issue[i]), .cdb(cdb), .grant(grant[i]),
            .busy(busy[i]), .request(request[i])
        );
    end

    cdb_arbiter #(.NUM_STATIONS(NUM_STATIONS)) arbiter (
        .clk(clk), .rst(rst),
        .request(request), .grant(grant), .cdb(cdb)
    );

endmodule

`default_nettype wire

// File: testbench/tb_ooo_core.sv
`timescale 1ns/100ps
`default_nettype none

module tb_ooo_core
    import ooo_pkg::*;
;

    localparam int MAX_ROWS = 40;

    logic      clk;
    logic      rst;
    dispatch_t dispatch;
    logic      dispatch_ready;
    commit_t   commit;
    redirect_t redirect;

    ooo_core #(.NUM_STATIONS(3)) UUT (
        .clk(clk), .rst(rst),
        .dispatch(dispatch), .dispatch_ready(dispatch_ready),
        .commit(commit), .redirect(redirect)
    );

    // ------------------------------------------------------------------
    // Stimulus table and expected results
    // ------------------------------------------------------------------
    op_t      row_op       [MAX_ROWS];
    reg_idx_t row_rd       [MAX_ROWS];
    word_t    row_imm      [MAX_ROWS];
    logic     row_has_imm  [MAX_ROWS];
    word_t    row_pc       [MAX_ROWS];
    int       row_src1     [MAX_ROWS];  // Producer row, or -1 for a direct value.
    int       row_src2     [MAX_ROWS];
    word_t    row_v1       [MAX_ROWS];
    word_t    row_v2       [MAX_ROWS];
    logic     row_squashed [MAX_ROWS];
    word_t    exp_value    [MAX_ROWS];
    logic     exp_redirect [MAX_ROWS];
    word_t    exp_target   [MAX_ROWS];
    rob_tag_t row_tag      [MAX_ROWS];
    logic     dispatched   [MAX_ROWS];
    logic     committed    [MAX_ROWS];

    int       num_rows = 0;
    int       next_live = 0;
    int       errors = 0;
    int       stall_cycles = 0;
    int       cycles = 0;
    int       seed = 77433;

    function automatic word_t reference_result(op_t op, word_t a, word_t b, word_t imm,
                                               word_t pc);
        logic [63:0] wide;
        wide = {{32{a[31]}}, a} >> b[4:0];
        case (op)
            OP_ADD:   return a + b;
            OP_SUB:   return a - b;
            OP_AND:   return a & b;
            OP_OR:    return a | b;
            OP_XOR:   return a ^ b;
            OP_SLL:   return a << b[4:0];
            OP_SRL:   return a >> b[4:0];
            OP_SRA:   return wide[31:0]; // Sign-filled shift.
            OP_SLT:   return {31'd0, (a ^ 32'h8000_0000) < (b ^ 32'h8000_0000)};
            OP_SLTU:  return {31'd0, a < b};
            OP_BEQ:   return {31'd0, a == b};
            OP_BNE:   return {31'd0, a != b};
            OP_BLT:   return {31'd0, (a ^ 32'h8000_0000) < (b ^ 32'h8000_0000)};
            OP_BGE:   return {31'd0, (a ^ 32'h8000_0000) >= (b ^ 32'h8000_0000)};
            OP_BLTU:  return {31'd0, a < b};
            OP_BGEU:  return {31'd0, a >= b};
            OP_LUI:   return imm;
            OP_AUIPC: return pc + imm;
            OP_JAL:   return pc + 32'd4;
            default:  return '0;
        endcase
    endfunction

    function automatic logic is_conditional(op_t op);
        return op inside {OP_BEQ, OP_BNE, OP_BLT, OP_BGE, OP_BLTU, OP_BGEU};
    endfunction

    function automatic rob_tag_t following_tag(rob_tag_t t);
        return (t == 3'd7) ? 3'd1 : t + 3'd1;
    endfunction

    // A source of -2 repeats the first operand, so branch outcomes are fixed.
    task automatic add_row(op_t op, reg_idx_t rd, word_t imm, logic has_imm, int s1, int s2,
                           logic squashed);
        word_t a;
        word_t b;
        int    n;
        n = num_rows;
        row_op[n] = op;
        row_rd[n] = rd;
        row_imm[n] = imm;
        row_has_imm[n] = has_imm;
        row_pc[n] = 32'h0000_1000 + word_t'(4 * n);
        row_src1[n] = s1;
        row_src2[n] = (s2 == -2) ? -1 : s2;
        row_v1[n] = $random(seed);
        row_v2[n] = (s2 == -2) ? row_v1[n] : $random(seed);
        row_squashed[n] = squashed;
        a = (s1 >= 0) ? exp_value[s1] : row_v1[n];
        b = (s2 >= 0) ? exp_value[s2] : row_v2[n];
        if (has_imm) begin
            b = imm;
        end
        exp_value[n] = reference_result(op, a, b, imm, row_pc[n]);
        exp_redirect[n] = (op == OP_JAL) || (is_conditional(op) && exp_value[n][0]);
        exp_target[n] = row_pc[n] + imm;
        dispatched[n] = 1'b0;
        committed[n] = 1'b0;
        num_rows++;
    endtask

    // Plays the register file by giving a value or the tag of a producer still in flight.
    task automatic resolve_operand(input int src, input word_t direct, output word_t value,
                                   output rob_tag_t tag);
        if (src < 0) begin
            value = direct;
            tag = 3'd0;
        end else if (committed[src] || (commit.valid && commit.tag == row_tag[src])) begin
            value = exp_value[src];
            tag = 3'd0;
        end else begin
            value = 32'hdead_beef;
            tag = row_tag[src];
        end
    endtask

    task automatic drive_row(int i);
        dispatch_t d;
        d.op = row_op[i];
        d.rd = row_rd[i];
        d.imm = row_imm[i];
        d.has_imm = row_has_imm[i];
        d.pc = row_pc[i];
        resolve_operand(row_src1[i], row_v1[i], d.value1, d.tag1);
        resolve_operand(row_src2[i], row_v2[i], d.value2, d.tag2);
        dispatch = d;
    endtask

    task automatic build_table();
        int k;
        // Every ALU operation with direct operands.
        add_row(OP_ADD, 5'd1, 32'd0, 1'b0, -1, -1, 1'b0);
        add_row(OP_SUB, 5'd2, 32'd0, 1'b0, -1, -1, 1'b0);
        add_row(OP_AND, 5'd3, 32'd0, 1'b0, -1, -1, 1'b0);
        add_row(OP_OR, 5'd4, 32'd0, 1'b0, -1, -1, 1'b0);
        add_row(OP_XOR, 5'd5, 32'd0, 1'b0, -1, -1, 1'b0);
        add_row(OP_SLL, 5'd6, 32'd0, 1'b0, -1, -1, 1'b0);
        add_row(OP_SRL, 5'd7, 32'd0, 1'b0, -1, -1, 1'b0);
        add_row(OP_SRA, 5'd8, 32'd0, 1'b0, -1, -1, 1'b0);
        add_row(OP_SLT, 5'd9, 32'd0, 1'b0, -1, -1, 1'b0);
        add_row(OP_SLTU, 5'd10, 32'd0, 1'b0, -1, -1, 1'b0);
        // Short dependent chain.
        add_row(OP_ADD, 5'd11, 32'd0, 1'b0, -1, -1, 1'b0);
        add_row(OP_SUB, 5'd12, 32'd0, 1'b0, 10, -1, 1'b0);
        add_row(OP_XOR, 5'd13, 32'd0, 1'b0, 11, 10, 1'b0);
        add_row(OP_ADD, 5'd16, 32'd5, 1'b1, 12, -1, 1'b0);
        add_row(OP_LUI, 5'd14, 32'h1234_5000, 1'b0, -1, -1, 1'b0);
        add_row(OP_AUIPC, 5'd15, 32'h0010_0000, 1'b0, -1, -1, 1'b0);
        // Each taken branch below is followed by a wrong-path row.
        add_row(OP_BEQ, 5'd0, 32'h40, 1'b0, -1, -2, 1'b0);
        add_row(OP_LUI, 5'd17, 32'h0000_7000, 1'b0, -1, -1, 1'b1);
        add_row(OP_BNE, 5'd0, 32'h40, 1'b0, -1, -2, 1'b0);
        add_row(OP_BLT, 5'd0, 32'h40, 1'b0, -1, -2, 1'b0);
        add_row(OP_BLTU, 5'd0, 32'h40, 1'b0, -1, -2, 1'b0);
        add_row(OP_BGE, 5'd0, 32'h24, 1'b0, -1, -2, 1'b0);
        add_row(OP_ADD, 5'd18, 32'd0, 1'b0, -1, -1, 1'b1);
        add_row(OP_BGEU, 5'd0, 32'h1c, 1'b0, -1, -2, 1'b0);
        add_row(OP_LUI, 5'd19, 32'h0000_9000, 1'b0, -1, -1, 1'b1);
        add_row(OP_JAL, 5'd1, 32'h80, 1'b0, -1, -1, 1'b0);
        add_row(OP_LUI, 5'd19, 32'h0000_a000, 1'b0, -1, -1, 1'b1);
        // Long chain that keeps every station busy, then independent work.
        add_row(OP_ADD, 5'd20, 32'd0, 1'b0, -1, -1, 1'b0);
        for (k = 0; k < 5; k++) begin
            add_row((k % 2 == 0) ? OP_SUB : OP_XOR, reg_idx_t'(21 + k), 32'd0, 1'b0,
                    num_rows - 1, -1, 1'b0);
        end
        add_row(OP_AND, 5'd26, 32'd0, 1'b0, num_rows - 1, 27, 1'b0);
        for (k = 0; k < 4; k++) begin
            add_row(OP_LUI, reg_idx_t'(27 + k), word_t'((k + 1) << 12), 1'b0, -1, -1, 1'b0);
        end
        add_row(OP_SLT, 5'd31, 32'd0, 1'b0, 33, 30, 1'b0);
    endtask

    // ------------------------------------------------------------------
    // Clock, timeout and commit checker
    // ------------------------------------------------------------------
    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (num_rows > 0 && cycles > num_rows * 20) begin
            $display("Timeout after %0d cycles with %0d of %0d commits seen, %0d errors",
                     cycles, next_live, num_rows, errors);
            $display("STATUS: FAIL");
            $finish;
        end
    end

    always @(negedge clk) begin
        if (rst && commit.valid) begin
            while (next_live < num_rows && row_squashed[next_live]) begin
                next_live++;
            end
            if (next_live >= num_rows) begin
                errors++;
                $display("Extra commit of tag %0d after the last instruction", commit.tag);
            end else if (!dispatched[next_live]) begin
                errors++;
                $display("Commit of tag %0d before row %0d was dispatched",
                         commit.tag, next_live);
            end else begin
                if (commit.tag !== row_tag[next_live]) begin
                    errors++;
                    $display("** Error: commit.tag = %h, expected %h (row %0d)",
                             commit.tag, row_tag[next_live], next_live);
                end
                if (commit.rd !== row_rd[next_live]) begin
                    errors++;
                    $display("** Error: commit.rd = %h, expected %h (row %0d)",
                             commit.rd, row_rd[next_live], next_live);
                end
                if (commit.value !== exp_value[next_live]) begin
                    errors++;
                    $display("** Error: commit.value = %h, expected %h (row %0d)",
                             commit.value, exp_value[next_live], next_live);
                end
                if (redirect.valid !== exp_redirect[next_live]) begin
                    errors++;
                    $display("** Error: redirect.valid = %h, expected %h (row %0d)",
                             redirect.valid, exp_redirect[next_live], next_live);
                end else if (redirect.valid && redirect.target !== exp_target[next_live]) begin
                    errors++;
                    $display("** Error: redirect.target = %h, expected %h (row %0d)",
                             redirect.target, exp_target[next_live], next_live);
                end
                committed[next_live] = 1'b1;
                next_live++;
            end
        end else if (redirect.valid) begin
            errors++;
            $display("Redirect raised without a commit");
        end
    end

    // ------------------------------------------------------------------
    // Main sequence
    // ------------------------------------------------------------------
    initial begin
        rob_tag_t tail;
        int       pending;
        int       i;
        logic     accepted;
        logic     skip;

        rst = 1'b0;
        dispatch = '0;
        dispatch.op = OP_NONE;
        tail = 3'd1;
        pending = -1;
        build_table();

        repeat (3) @(posedge clk);
        #1 rst = 1'b1;
        repeat (3) @(posedge clk);
        #1;

        for (i = 0; i < num_rows; i++) begin
            if (!row_squashed[i] && pending >= 0) begin
                while (!committed[pending]) begin
                    @(posedge clk);
                    #1;
                end
                tail = following_tag(row_tag[pending]); // Flush restarts behind the jump.
                pending = -1;
            end
            accepted = 1'b0;
            skip = 1'b0;
            while (!accepted && !skip) begin
                if (row_squashed[i] && pending >= 0 && committed[pending]) begin
                    skip = 1'b1;
                end else begin
                    drive_row(i);
                    @(negedge clk);
                    if (dispatch_ready) begin
                        accepted = 1'b1;
                    end else begin
                        stall_cycles++;
                    end
                    @(posedge clk);
                    #1;
                    dispatch.op = OP_NONE;
                end
            end
            if (accepted) begin
                row_tag[i] = tail;
                dispatched[i] = 1'b1;
                tail = following_tag(tail);
                if (exp_redirect[i] && !row_squashed[i]) begin
                    pending = i;
                end
            end
        end

        while (next_live < num_rows) begin
            @(posedge clk);
        end
        repeat (10) @(posedge clk);

        if (stall_cycles == 0) begin
            errors++;
            $display("dispatch_ready never dropped while the stations were full");
        end
        $display("Run finished: %0d errors, %0d stall cycles", errors, stall_cycles);
        if (errors == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: tb.f
source/ooo_pkg.sv
source/reorder_buffer.sv
source/issue_router.sv
source/alu_station.sv
source/cdb_arbiter.sv
source/ooo_core.sv
testbench/tb_ooo_core.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the testbench with Verilator, then decide from the log.
set -e
cd "$(dirname "$0")"

verilator --binary --timing -j 0 --top-module tb_ooo_core -f tb.f -o sim_ooo_core
./obj_dir/sim_ooo_core > sim.log
cat sim.log

if grep -q "^STATUS: PASS$" sim.log; then
    exit 0
fi
exit 1
